//--- soc_timer.f
design/bus_pkg.sv
design/timer_pkg.sv
design/tick_divider.sv
design/clint.sv
design/scratch_ram.sv
design/bus_decoder.sv
design/soc_timer_top.sv
tests/soc_timer_assert.sv
tests/soc_timer_tb.sv

//--- tests/soc_timer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_timer_tb;

  typedef struct packed {
    bit          write;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic [63:0] exp;        // lower bound for window rows
    logic [63:0] mask;
    logic        err;
    logic [1:0]  irq_mask;   // lanes of {msip, mtip} that are compared
    logic [1:0]  irq_exp;
    bit          window;     // mtime reads land between exp and hi
    bit          after_prev; // lower bound is the previous window read
    logic [63:0] hi;
    int          idle;
  } row_t;

  localparam logic [63:0] all_ones = '1;

  logic        clock = 1'b0;
  logic        reset;
  logic        valid;
  logic [31:0] addr;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  logic [63:0] rdata;
  logic        ready;
  logic        bus_error;
  logic        msip;
  logic        mtip;
  logic [63:0] mtime;
  row_t        rows[$];
  logic [63:0] ram_model [bus_pkg::ram_words];
  logic [63:0] last_window;
  int          drive_row = -1;
  int          check_row = -1;
  int          total_idle = 0;
  int          errors = 0;
  int          checks = 0;
  bit          table_done = 1'b0;

  soc_timer_top soc_timer_top_inst (.*);

  always #50 clock = ~clock;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s is %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic add_row(input bit write, input logic [31:0] a, input logic [63:0] d,
                         input logic [7:0] s, input logic [63:0] exp,
                         input logic [63:0] mask, input logic err,
                         input logic [1:0] irq_mask, input logic [1:0] irq_exp,
                         input int idle);
    rows.push_back({write, a, d, s, exp, mask, err, irq_mask, irq_exp,
                    1'b0, 1'b0, 64'h0, idle});
    total_idle += idle;
  endtask

  task automatic add_window(input logic [31:0] a, input logic [63:0] lo,
                            input logic [63:0] hi, input bit after_prev, input int idle);
    rows.push_back({1'b0, a, 64'h0, 8'h00, lo, 64'h0, 1'b0, 2'b00, 2'b00,
                    1'b1, after_prev, hi, idle});
    total_idle += idle;
  endtask

  function automatic logic [31:0] ram_addr(input int word);
    return bus_pkg::ram_base + 32'(word * bus_pkg::strb_width);
  endfunction

  function automatic logic [31:0] timer_addr(input logic [15:0] offset);
    return bus_pkg::clint_base + 32'(offset);
  endfunction

  task automatic add_ram_write(input int word, input logic [7:0] strb);
    logic [63:0] data;
    data = {$urandom, $urandom};
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        ram_model[word][8*b +: 8] = data[8*b +: 8]; // unstrobed bytes keep the old word
      end
    end
    add_row(1'b1, ram_addr(word), data, strb, 64'h0, all_ones, 1'b0, 2'b00, 2'b00, 0);
  endtask

  task automatic add_ram_read(input int word);
    add_row(1'b0, ram_addr(word), 64'h0, 8'h00, ram_model[word], all_ones, 1'b0, 2'b00,
            2'b00, 0);
  endtask

  task automatic build_table();
    logic [31:0] msip_a;
    logic [31:0] cmp_a;
    logic [31:0] time_a;
    msip_a = timer_addr(timer_pkg::msip_offset);
    cmp_a = timer_addr(timer_pkg::mtimecmp_offset);
    time_a = timer_addr(timer_pkg::mtime_offset);
    add_ram_write(0, 8'hFF);
    add_ram_write(1, 8'hFF);
    add_ram_write(511, 8'hFF);
    add_ram_write(1, 8'h0F);
    add_ram_read(1);
    add_ram_write(511, 8'hA5);
    add_ram_write(0, 8'h80);
    add_ram_read(0);
    add_ram_read(511);
    add_ram_read(1);
    // outside both regions, then just past each edge of the map
    add_row(1'b0, 32'h0000_0000, 64'h0, 8'h00, 64'h0, all_ones, 1'b1, 2'b00, 2'b00, 0);
    add_row(1'b1, 32'h1000_0000, {$urandom, $urandom}, 8'hFF, 64'h0, all_ones, 1'b1,
            2'b00, 2'b00, 0);
    add_row(1'b0, bus_pkg::ram_base + bus_pkg::ram_size, 64'h0, 8'h00, 64'h0, all_ones,
            1'b1, 2'b00, 2'b00, 0);
    add_row(1'b0, bus_pkg::clint_base + bus_pkg::clint_size, 64'h0, 8'h00, 64'h0,
            all_ones, 1'b1, 2'b00, 2'b00, 0);
    add_row(1'b0, bus_pkg::clint_base - 32'd8, 64'h0, 8'h00, 64'h0, all_ones, 1'b1,
            2'b00, 2'b00, 0);
    add_row(1'b1, timer_addr(16'h2000), all_ones, 8'hFF, 64'h0, all_ones, 1'b0, 2'b00,
            2'b00, 0);
    add_row(1'b0, timer_addr(16'h2000), 64'h0, 8'h00, 64'h0, all_ones, 1'b0, 2'b00,
            2'b00, 0);
    add_row(1'b1, msip_a, 64'h1, 8'h0F, 64'h0, all_ones, 1'b0, 2'b10, 2'b10, 0);
    add_row(1'b0, msip_a, 64'h0, 8'h00, 64'h1, all_ones, 1'b0, 2'b10, 2'b10, 0);
    add_row(1'b1, msip_a, 64'h0, 8'h01, 64'h0, all_ones, 1'b0, 2'b10, 2'b00, 0);
    add_row(1'b0, msip_a, 64'h0, 8'h00, 64'h0, all_ones, 1'b0, 2'b10, 2'b00, 0);
    add_row(1'b1, cmp_a, all_ones, 8'hFF, 64'h0, all_ones, 1'b0, 2'b00, 2'b00, 1);
    add_row(1'b0, cmp_a, 64'h0, 8'h00, all_ones, all_ones, 1'b0, 2'b01, 2'b00, 0);
    add_row(1'b1, time_a, 64'h1000, 8'hFF, 64'h0, all_ones, 1'b0, 2'b00, 2'b00, 24);
    add_window(time_a, 64'h1000, 64'h1000 + 24 / timer_pkg::tick_period + 1, 1'b0, 40);
    add_window(time_a, 64'h0, 64'h1000 + (24 + 1 + 40) / timer_pkg::tick_period + 1,
               1'b1, 0);
    // mtimecmp a few ticks ahead of mtime, so mtip rises only after the wait
    add_row(1'b1, time_a, 64'h2000, 8'hFF, 64'h0, all_ones, 1'b0, 2'b00, 2'b00, 0);
    add_row(1'b1, cmp_a, 64'h2003, 8'hFF, 64'h0, all_ones, 1'b0, 2'b00, 2'b00, 1);
    add_row(1'b0, cmp_a, 64'h0, 8'h00, 64'h2003, all_ones, 1'b0, 2'b01, 2'b00,
            4 * timer_pkg::tick_period + 4);
    add_row(1'b0, cmp_a, 64'h0, 8'h00, 64'h2003, all_ones, 1'b0, 2'b01, 2'b01, 0);
    add_row(1'b1, time_a, 64'h0, 8'hFF, 64'h0, all_ones, 1'b0, 2'b00, 2'b00, 1);
    add_row(1'b0, cmp_a, 64'h0, 8'h00, 64'h2003, all_ones, 1'b0, 2'b01, 2'b00, 0);
  endtask

  task automatic drive_idle();
    valid <= 1'b0;
    wstrb <= 8'h00;
    drive_row <= -1;
  endtask

  always @(posedge clock) begin
    check_row <= drive_row; // the row whose response is due after this edge
  end

  always @(negedge clock) begin : response_check
    row_t        r;
    logic [63:0] lo;
    if (check_row >= 0) begin
      r = rows[check_row];
      if (ready !== 1'b1) begin
        errors++;
        $display("row %0d got no ready one cycle after its request", check_row);
      end else begin
        check_value("bus_error", bus_error, r.err);
        if (r.window) begin
          lo = r.after_prev ? last_window : r.exp;
          check_value("rdata low bound", (rdata < lo) ? rdata : lo, lo);
          check_value("rdata high bound", (rdata > r.hi) ? rdata : r.hi, r.hi);
          // the mtime output may have taken one more tick than the read data
          check_value("mtime low bound", (mtime < lo) ? mtime : lo, lo);
          check_value("mtime high bound", (mtime > r.hi) ? mtime : r.hi, r.hi);
          last_window = rdata;
        end else begin
          check_value("rdata", rdata & r.mask, r.exp & r.mask);
        end
        if (r.irq_mask != 2'b00) begin
          check_value("{msip, mtip}", {msip, mtip} & r.irq_mask, r.irq_exp & r.irq_mask);
        end
      end
    end else if (reset === 1'b1 && ready !== 1'b0) begin
      errors++;
      $display("ready was high with no request in the previous cycle");
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_done);
    limit = rows.size() + total_idle + 16 + 64;
    #(limit * 100);
    $display("timeout, the run did not finish within %0d clock cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h9174));
    reset = 1'b0;
    valid = 1'b0;
    addr = '0;
    wdata = '0;
    wstrb = '0;
    build_table();
    table_done = 1'b1;
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    foreach (rows[i]) begin
      @(posedge clock);
      valid <= 1'b1;
      addr <= rows[i].addr;
      wdata <= rows[i].wdata;
      wstrb <= rows[i].write ? rows[i].wstrb : 8'h00;
      drive_row <= i;
      repeat (rows[i].idle) begin
        @(posedge clock);
        drive_idle();
      end
    end
    @(posedge clock);
    drive_idle();
    repeat (2) @(posedge clock);
    $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/soc_timer_assert.sv
`timescale 1ns/1ps
`default_nettype none

module soc_timer_assert (
  input logic             clock,
  input logic             reset,
  input logic             valid,
  input logic             ready,
  input logic             bus_error,
  input logic             mtip,
  input logic [63:0]      mtime,
  input logic [63:0]      mtimecmp,
  input bus_pkg::region_t region
);

  ready_after_valid: assert property (@(posedge clock) disable iff (!reset)
    valid |=> ready)
    else $error("ready did not follow valid by exactly one cycle");

  ready_needs_valid: assert property (@(posedge clock) disable iff (!reset)
    ready |-> $past(valid))
    else $error("ready rose without a valid in the previous cycle");

  // only the unmapped responder raises an error
  error_from_unmapped: assert property (@(posedge clock) disable iff (!reset)
    bus_error |-> ready && $past(valid) && ($past(region) == bus_pkg::region_none))
    else $error("bus_error without ready or for a mapped address");

  mtip_follows_compare: assert property (@(posedge clock) disable iff (!reset)
    (mtime < mtimecmp) |=> !mtip)
    else $error("mtip high although mtime was below mtimecmp");

endmodule

bind soc_timer_top soc_timer_assert soc_timer_assert_inst (
  .clock    (clock),
  .reset    (reset),
  .valid    (valid),
  .ready    (ready),
  .bus_error(bus_error),
  .mtip     (mtip),
  .mtime    (mtime),
  .mtimecmp (clint_inst.mtimecmp),
  .region   (bus_decoder_inst.region)
);

`default_nettype wire

//--- design/soc_timer_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_timer_top (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           valid,
  input  logic [bus_pkg::addr_width-1:0] addr,
  input  logic [bus_pkg::data_width-1:0] wdata,
  input  logic [bus_pkg::strb_width-1:0] wstrb,
  output logic [bus_pkg::data_width-1:0] rdata,
  output logic                           ready,
  output logic                           bus_error,
  output logic                           msip,
  output logic                           mtip,
  output logic [63:0]                    mtime
);

  logic                           clint_select;
  logic                           ram_select;
  logic [bus_pkg::data_width-1:0] clint_rdata;
  logic [bus_pkg::data_width-1:0] ram_rdata;
  logic                           clint_ready;
  logic                           ram_ready;

  bus_decoder bus_decoder_inst (
    .clock       (clock),
    .reset       (reset),
    .valid       (valid),
    .addr        (addr),
    .clint_select(clint_select),
    .ram_select  (ram_select),
    .clint_rdata (clint_rdata),
    .ram_rdata   (ram_rdata),
    .clint_ready (clint_ready),
    .ram_ready   (ram_ready),
    .rdata       (rdata),
    .ready       (ready),
    .bus_error   (bus_error)
  );

  clint clint_inst (
    .clock (clock),
    .reset (reset),
    .select(clint_select),
    .addr  (addr),
    .wdata (wdata),
    .wstrb (wstrb),
    .rdata (clint_rdata),
    .ready (clint_ready),
    .mtime (mtime),
    .msip  (msip),
    .mtip  (mtip)
  );

  scratch_ram scratch_ram_inst (
    .clock (clock),
    .reset (reset),
    .select(ram_select),
    .addr  (addr),
    .wdata (wdata),
    .wstrb (wstrb),
    .rdata (ram_rdata),
    .ready (ram_ready)
  );

endmodule

`default_nettype wire

//--- design/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           valid,
  input  logic [bus_pkg::addr_width-1:0] addr,
  output logic                           clint_select,
  output logic                           ram_select,
  input  logic [bus_pkg::data_width-1:0] clint_rdata,
  input  logic [bus_pkg::data_width-1:0] ram_rdata,
  input  logic                           clint_ready,
  input  logic                           ram_ready,
  output logic [bus_pkg::data_width-1:0] rdata,
  output logic                           ready,
  output logic                           bus_error
);

  bus_pkg::region_t region;
  logic             unmapped;

  always_comb begin
    if (addr >= bus_pkg::clint_base &&
        addr < bus_pkg::clint_base + bus_pkg::clint_size) begin
      region = bus_pkg::region_clint;
    end else if (addr >= bus_pkg::ram_base &&
                 addr < bus_pkg::ram_base + bus_pkg::ram_size) begin
      region = bus_pkg::region_ram;
    end else begin
      region = bus_pkg::region_none;
    end
  end

  assign clint_select = valid && (region == bus_pkg::region_clint);
  assign ram_select = valid && (region == bus_pkg::region_ram);

  // the unmapped responder answers on the same cycle a target would
  always_ff @(posedge clock) begin
    if (!reset) begin
      unmapped <= 1'b0;
    end else begin
      unmapped <= valid && (region == bus_pkg::region_none);
    end
  end

  // only one responder is active per cycle, idle ones drive zero
  assign rdata = clint_rdata | ram_rdata;
  assign ready = clint_ready | ram_ready | unmapped;
  assign bus_error = unmapped;

endmodule

`default_nettype wire

//--- design/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           select,
  input  logic [bus_pkg::addr_width-1:0] addr,
  input  logic [bus_pkg::data_width-1:0] wdata,
  input  logic [bus_pkg::strb_width-1:0] wstrb,
  output logic [bus_pkg::data_width-1:0] rdata,
  output logic                           ready
);

  logic [bus_pkg::data_width-1:0]      mem [bus_pkg::ram_words];
  logic [bus_pkg::ram_index_width-1:0] index;
  logic                                write;

  assign index = addr[bus_pkg::byte_offset_width +: bus_pkg::ram_index_width];
  assign write = |wstrb;

  always_ff @(posedge clock) begin
    if (select && write) begin
      for (int i = 0; i < bus_pkg::strb_width; i++) begin
        if (wstrb[i]) begin
          mem[index][8*i +: 8] <= wdata[8*i +: 8]; // only strobed lanes change
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    rdata <= (select && !write) ? mem[index] : '0; // zero unless answering a read
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= select;
    end
  end

endmodule

`default_nettype wire

//--- design/clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           select,
  input  logic [bus_pkg::addr_width-1:0] addr,
  input  logic [bus_pkg::data_width-1:0] wdata,
  input  logic [bus_pkg::strb_width-1:0] wstrb,
  output logic [bus_pkg::data_width-1:0] rdata,
  output logic                           ready,
  output logic [63:0]                    mtime,
  output logic                           msip,
  output logic                           mtip
);

  logic                                 tick;
  logic [timer_pkg::offset_width-1:0]   offset;
  logic                                 write;
  logic                                 msip_hit;
  logic                                 mtimecmp_hit;
  logic                                 mtime_hit;
  logic [63:0]                          mtimecmp;
  logic [bus_pkg::data_width-1:0]       read_value;

  tick_divider tick_divider_inst (
    .clock(clock),
    .reset(reset),
    .tick (tick)
  );

  assign offset = addr[timer_pkg::offset_width-1:0];
  assign write = |wstrb; // timer writes always replace the whole register

  // the wrapping subtraction turns each range check into a single compare
  assign msip_hit = (offset - timer_pkg::msip_offset) < timer_pkg::msip_size;
  assign mtimecmp_hit = (offset - timer_pkg::mtimecmp_offset) < timer_pkg::mtimecmp_size;
  assign mtime_hit = (offset - timer_pkg::mtime_offset) < timer_pkg::mtime_size;

  always_comb begin
    read_value = '0; // offsets that name no register read as zero
    if (msip_hit) begin
      read_value[0] = msip;
    end else if (mtimecmp_hit) begin
      read_value = mtimecmp;
    end else if (mtime_hit) begin
      read_value = mtime;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      msip <= 1'b0;
    end else if (select && write && msip_hit) begin
      msip <= wdata[0];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtimecmp <= '0;
    end else if (select && write && mtimecmp_hit) begin
      mtimecmp <= wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtime <= '0;
    end else if (select && write && mtime_hit) begin
      mtime <= wdata; // a software write wins over a tick in the same cycle
    end else if (tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtip <= 1'b0;
    end else begin
      mtip <= (mtime >= mtimecmp);
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= select; // every access is answered, unused offsets included
    end
  end

  always_ff @(posedge clock) begin
    rdata <= (select && !write) ? read_value : '0;
  end

endmodule

`default_nettype wire

//--- design/tick_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tick_divider (
  input  logic clock,
  input  logic reset,
  output logic tick
);

  logic [timer_pkg::tick_width-1:0] count;

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
      tick <= 1'b0;
    end else if (count == timer_pkg::tick_last) begin
      count <= '0;
      tick <= 1'b1; // single cycle pulse as the counter wraps
    end else begin
      count <= count + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/timer_pkg.sv
`default_nettype none

package timer_pkg;

  localparam int tick_period = 8; // clock cycles per mtime step in simulation
  localparam int tick_width = $clog2(tick_period);
  localparam logic [tick_width-1:0] tick_last = tick_width'(tick_period - 1);

  // register offsets inside the timer window, with their sizes in bytes
  localparam int offset_width = 16;
  localparam logic [offset_width-1:0] msip_offset = 16'h0000;
  localparam logic [offset_width-1:0] msip_size = 16'd4;
  localparam logic [offset_width-1:0] mtimecmp_offset = 16'h4000;
  localparam logic [offset_width-1:0] mtimecmp_size = 16'd8;
  localparam logic [offset_width-1:0] mtime_offset = 16'hBFF8;
  localparam logic [offset_width-1:0] mtime_size = 16'd8;

endpackage

`default_nettype wire

//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 64;
  localparam int strb_width = data_width / 8; // one strobe per byte lane
  localparam int byte_offset_width = $clog2(strb_width);

  localparam logic [addr_width-1:0] clint_base = 32'h0200_0000;
  localparam logic [addr_width-1:0] clint_size = 32'h0001_0000; // 64 KiB timer window

  localparam logic [addr_width-1:0] ram_base = 32'h8000_0000;
  localparam int ram_words = 512;
  localparam int ram_index_width = $clog2(ram_words);
  localparam logic [addr_width-1:0] ram_size = addr_width'(ram_words * strb_width);

  // target chosen for an access by the address decoder
  typedef enum logic [1:0] {
    region_none,
    region_clint,
    region_ram
  } region_t;

endpackage

`default_nettype wire
